//--- design/drng_pkg.sv
// drng package: shared widths, seed slot struct and mixing defaults for the drng subsystem.
`default_nettype none

package drng_pkg;

   // key, value and reseed interval widths.
   localparam int drng_key_w   = 256;
   localparam int drng_value_w = 128;
   localparam int drng_life_w  = 48;

   // an all-ones interval puts the slot in test mode.
   localparam logic [drng_life_w-1:0] drng_test_life = {drng_life_w{1'b1}};

   // default left rotation of the keyed mix.
   localparam int drng_mix_rotate_default = 7;

   // one seed slot as the provider hands it over.
   typedef struct packed {
      logic [drng_key_w-1:0]   key;    // upper half and lower half used separately.
      logic [drng_value_w-1:0] value;  // running counter value.
      logic [drng_life_w-1:0]  life;   // words left before reseed.
   } drng_seed_t;

endpackage

`default_nettype wire

//--- design/drng_seed_select.sv
// drng seed selection: picks the active seed slot and drives invalidate, reseed and empty status.
`timescale 1ns/1ps
`default_nettype none

module drng_seed_select (
   input  logic                 clk,
   input  logic                 rst_n,
   input  drng_pkg::drng_seed_t seed0,
   input  drng_pkg::drng_seed_t seed1,
   input  logic                 seed0_valid,
   input  logic                 seed1_valid,
   input  logic                 seed_expired,
   output logic                 start,
   output drng_pkg::drng_seed_t seed_sel,
   output logic                 seed0_invalidate,
   output logic                 seed1_invalidate,
   output logic                 stat_drbg_reseed,
   output logic                 drng_seed_expired
);

   import drng_pkg::*;

   drng_seed_t slot_seed [2];
   logic [1:0] slot_valid;
   logic       sel_q;        // active slot pointer.
   logic       sel_valid;
   logic       other_valid;

   assign slot_seed[0] = seed0;
   assign slot_seed[1] = seed1;
   assign slot_valid   = {seed1_valid, seed0_valid};

   assign sel_valid   = slot_valid[sel_q];
   assign other_valid = slot_valid[~sel_q];

   // the core sees whatever slot the pointer names.
   assign seed_sel = slot_seed[sel_q];
   assign start    = sel_valid;

   assign seed0_invalidate = seed0_valid & seed_expired & (sel_q == 1'b0);
   assign seed1_invalidate = seed1_valid & seed_expired & (sel_q == 1'b1);

   assign stat_drbg_reseed  = seed0_invalidate | seed1_invalidate;
   assign drng_seed_expired = ~(seed0_valid | seed1_valid);  // nothing left to run on.

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sel_q <= 1'b0;
      end
      else begin
         if (sel_valid) begin
            // hand over to the other slot when this one is used up.
            if (seed_expired) begin
               sel_q <= ~sel_q;
            end
         end
         else if (other_valid) begin
            sel_q <= ~sel_q;  // empty slot, look at the other one.
         end
      end
   end

endmodule

`default_nettype wire

//--- design/drng_core.sv
// drng generator core: loads a seed, produces keyed mix words on ack and counts down seed life.
`timescale 1ns/1ps
`default_nettype none

module drng_core #(
   parameter int mix_rotate = drng_pkg::drng_mix_rotate_default
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               start,
   input  drng_pkg::drng_seed_t               seed,
   input  logic                               drng_ack,
   output logic                               drng_valid,
   output logic [drng_pkg::drng_value_w-1:0] raw_word,
   output logic                               seed_expired,
   output logic                               idle
);

   import drng_pkg::*;

   typedef enum logic {
      st_idle,
      st_run
   } state_t;

   state_t                  state_q;
   logic                    valid_q;
   logic [drng_key_w-1:0]   key_q;
   logic [drng_value_w-1:0] value_q;
   logic [drng_life_w-1:0]  life_q;
   logic [drng_value_w-1:0] word_q;
   logic                    load;
   logic                    first_word;
   logic                    take;
   logic                    last_word;

   // keyed mix standing in for the block cipher.
   function automatic logic [drng_value_w-1:0] mix(
      input logic [drng_key_w-1:0]   key,
      input logic [drng_value_w-1:0] value
   );
      logic [drng_value_w-1:0] x;
      logic [drng_value_w-1:0] r;
      x = value ^ key[drng_value_w-1:0];
      r = (x << mix_rotate) | (x >> (drng_value_w - mix_rotate));
      return r ^ key[drng_key_w-1:drng_value_w];
   endfunction

   assign load       = (state_q == st_idle) && start;
   assign first_word = (state_q == st_run) && !valid_q;   // one cycle after load.
   assign take       = valid_q && drng_ack;
   assign last_word  = (life_q <= 48'd1);                   // life of zero also ends here.

   assign seed_expired = take && last_word;
   assign drng_valid   = valid_q;
   assign raw_word     = word_q;
   assign idle         = (state_q == st_idle);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= st_idle;
         valid_q <= 1'b0;
      end
      else begin
         case (state_q)
            st_idle: begin
               if (start) begin
                  state_q <= st_run;
               end
            end
            st_run: begin
               if (first_word) begin
                  valid_q <= 1'b1;
               end
               else if (seed_expired) begin
                  valid_q <= 1'b0;
                  state_q <= st_idle;  // wait for the next slot.
               end
            end
            default: begin
               state_q <= st_idle;
               valid_q <= 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         key_q   <= seed.key;
         value_q <= seed.value;
         life_q  <= seed.life;
      end
      else if (take && !last_word) begin
         value_q <= value_q + 1'b1;
         life_q  <= life_q - 1'b1;
      end

      if (first_word) begin
         word_q <= mix(key_q, value_q);
      end
      else if (take && !last_word) begin
         word_q <= mix(key_q, value_q + 1'b1);  // next word ready one cycle after ack.
      end
   end

endmodule

`default_nettype wire

//--- design/drng_health_monitor.sv
// drng health monitor: repeat-word test on acknowledged words and test-mode output zeroing.
`timescale 1ns/1ps
`default_nettype none

module drng_health_monitor (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [drng_pkg::drng_value_w-1:0] raw_word,
   input  logic [drng_pkg::drng_life_w-1:0]  life,
   input  logic                               drng_ack,
   output logic [drng_pkg::drng_value_w-1:0] drng_out,
   output logic                               health_fail
);

   import drng_pkg::*;

   logic [drng_value_w-1:0] last_q;   // last acknowledged word.
   logic                    first_q;  // set once any word was acked.
   logic                    test_mode;

   assign test_mode = (life == drng_test_life);
   assign drng_out  = test_mode ? '0 : raw_word;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         first_q     <= 1'b0;
         health_fail <= 1'b0;
      end
      else if (drng_ack) begin
         first_q <= 1'b1;
         if (first_q && (last_q == drng_out)) begin
            health_fail <= 1'b1;
         end
         else begin
            health_fail <= 1'b0;
         end
      end
   end

   // compared value only matters once first_q is set.
   always_ff @(posedge clk) begin
      if (drng_ack) begin
         last_q <= drng_out;
      end
   end

endmodule

`default_nettype wire

//--- design/kme_drng_top.sv
// kme drng top level: seed selection, generator core and health monitor.
`timescale 1ns/1ps
`default_nettype none

module kme_drng_top #(
   parameter int mix_rotate = drng_pkg::drng_mix_rotate_default
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  drng_pkg::drng_seed_t               seed0,
   input  drng_pkg::drng_seed_t               seed1,
   input  logic                               seed0_valid,
   input  logic                               seed1_valid,
   input  logic                               drng_ack,
   output logic [drng_pkg::drng_value_w-1:0] drng_out,
   output logic                               drng_valid,
   output logic                               drng_health_fail,
   output logic                               drng_seed_expired,
   output logic                               seed0_invalidate,
   output logic                               seed1_invalidate,
   output logic                               stat_drbg_reseed,
   output logic                               drng_idle
);

   import drng_pkg::*;

   drng_seed_t              seed_sel;
   logic                    start;
   logic                    seed_expired;
   logic [drng_value_w-1:0] raw_word;

   drng_seed_select u_seed_select (
      .clk               (clk),
      .rst_n             (rst_n),
      .seed0             (seed0),
      .seed1             (seed1),
      .seed0_valid       (seed0_valid),
      .seed1_valid       (seed1_valid),
      .seed_expired      (seed_expired),
      .start             (start),
      .seed_sel          (seed_sel),
      .seed0_invalidate  (seed0_invalidate),
      .seed1_invalidate  (seed1_invalidate),
      .stat_drbg_reseed  (stat_drbg_reseed),
      .drng_seed_expired (drng_seed_expired)
   );

   drng_core #(
      .mix_rotate (mix_rotate)
   ) u_core (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .seed         (seed_sel),
      .drng_ack     (drng_ack),
      .drng_valid   (drng_valid),
      .raw_word     (raw_word),
      .seed_expired (seed_expired),
      .idle         (drng_idle)
   );

   // test mode follows the selected slot's interval.
   drng_health_monitor u_health_monitor (
      .clk         (clk),
      .rst_n       (rst_n),
      .raw_word    (raw_word),
      .life        (seed_sel.life),
      .drng_ack    (drng_ack),
      .drng_out    (drng_out),
      .health_fail (drng_health_fail)
   );

endmodule

`default_nettype wire

//--- test/drng_checker.sv
// drng protocol checker: concurrent assertions on invalidate, reseed, valid and health status.
`timescale 1ns/1ps
`default_nettype none

module drng_checker (
   input  logic clk,
   input  logic rst_n,
   input  logic drng_ack,
   input  logic drng_valid,
   input  logic drng_idle,
   input  logic drng_health_fail,
   input  logic seed0_invalidate,
   input  logic seed1_invalidate,
   input  logic stat_drbg_reseed
);

   import drng_pkg::*;

   int fail_count = 0;  // failed assertions so far.

   // only one slot can be the one that just ran out.
   a_one_invalidate: assert property (@(posedge clk) disable iff (!rst_n)
      !(seed0_invalidate && seed1_invalidate))
   else begin
      $error("both seed slots invalidated in the same cycle");
      fail_count++;
   end

   a_reseed_or: assert property (@(posedge clk) disable iff (!rst_n)
      stat_drbg_reseed == (seed0_invalidate || seed1_invalidate))
   else begin
      $error("reseed strobe differs from the OR of the invalidates");
      fail_count++;
   end

   a_valid_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !(drng_valid && drng_idle))
   else begin
      $error("word offered while the core reports idle");
      fail_count++;
   end

   // health status moves only on the edge that takes a word.
   a_fail_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
      $changed(drng_health_fail) |-> $past(drng_ack))
   else begin
      $error("health fail changed without a preceding ack");
      fail_count++;
   end

endmodule

bind kme_drng_top drng_checker u_checker (
   .clk              (clk),
   .rst_n            (rst_n),
   .drng_ack         (drng_ack),
   .drng_valid       (drng_valid),
   .drng_idle        (drng_idle),
   .drng_health_fail (drng_health_fail),
   .seed0_invalidate (seed0_invalidate),
   .seed1_invalidate (seed1_invalidate),
   .stat_drbg_reseed (stat_drbg_reseed)
);

`default_nettype wire

//--- test/drng_tb.sv
// drng testbench: seed provider model, reference mix and word-by-word comparison with the top level.
`timescale 1ns/1ps
`default_nettype none

module drng_tb;

   import drng_pkg::*;

   localparam int rotate     = drng_mix_rotate_default;
   localparam int wait_limit = 50;   // cycles per wait.

   logic                    clk;
   logic                    rst_n;
   drng_seed_t              seed0;
   drng_seed_t              seed1;
   logic                    seed0_valid;
   logic                    seed1_valid;
   logic                    drng_ack;
   logic [drng_value_w-1:0] drng_out;
   logic                    drng_valid;
   logic                    drng_health_fail;
   logic                    drng_seed_expired;
   logic                    seed0_invalidate;
   logic                    seed1_invalidate;
   logic                    stat_drbg_reseed;
   logic                    drng_idle;

   // provider copy of the active seed.
   logic                    mdl_loaded;
   logic                    mdl_slot;
   logic [drng_key_w-1:0]   mdl_key;
   logic [drng_value_w-1:0] mdl_value;
   logic [drng_life_w-1:0]  mdl_life;
   logic [drng_life_w-1:0]  mdl_seed_life;
   int                      mdl_age;   // cycles since the seed was taken.
   logic [drng_value_w-1:0] prev_word;
   logic                    have_prev;
   logic                    exp_fail;
   logic [1:0]              drop_pending;
   logic                    timed_out;

   int mismatch_count;
   int other_count;
   int word_count;

   kme_drng_top #(
      .mix_rotate (drng_mix_rotate_default)
   ) dut0 (
      .clk               (clk),
      .rst_n             (rst_n),
      .seed0             (seed0),
      .seed1             (seed1),
      .seed0_valid       (seed0_valid),
      .seed1_valid       (seed1_valid),
      .drng_ack          (drng_ack),
      .drng_out          (drng_out),
      .drng_valid        (drng_valid),
      .drng_health_fail  (drng_health_fail),
      .drng_seed_expired (drng_seed_expired),
      .seed0_invalidate  (seed0_invalidate),
      .seed1_invalidate  (seed1_invalidate),
      .stat_drbg_reseed  (stat_drbg_reseed),
      .drng_idle         (drng_idle)
   );

   always begin
      #50 clk = ~clk;
   end

   // expected word: value xor low key, rotated left, xor high key; zero in test mode.
   function automatic logic [drng_value_w-1:0] ref_word(
      input logic [drng_key_w-1:0]   key,
      input logic [drng_value_w-1:0] value,
      input logic [drng_life_w-1:0]  seed_life
   );
      logic [drng_value_w-1:0]   x;
      logic [2*drng_value_w-1:0] twice;
      x     = value ^ key[drng_value_w-1:0];
      twice = {x, x} << rotate;
      if (&seed_life) begin
         return '0;
      end
      return twice[2*drng_value_w-1:drng_value_w] ^ key[drng_key_w-1:drng_value_w];
   endfunction

   function automatic drng_seed_t random_seed(input logic [drng_life_w-1:0] life);
      drng_seed_t s;
      for (int i = 0; i < drng_key_w / 32; i++) begin
         s.key[i*32 +: 32] = $urandom;
      end
      for (int i = 0; i < drng_value_w / 32; i++) begin
         s.value[i*32 +: 32] = $urandom;
      end
      s.life = life;
      return s;
   endfunction

   // provider drops a slot one cycle after its invalidate.
   always @(negedge clk) begin
      drop_pending <= {seed1_invalidate, seed0_invalidate};
   end

   always @(posedge clk) begin
      if (drop_pending[0]) begin
         seed0_valid <= 1'b0;
      end
      if (drop_pending[1]) begin
         seed1_valid <= 1'b0;
      end
   end

   // compares every offered word and the status strobes against the model.
   always @(negedge clk) begin : compare
      logic [drng_value_w-1:0] exp_word;
      logic                    exp_valid;
      logic                    last;
      logic                    exp_inv;
      drng_seed_t              s;
      if (rst_n) begin
         assert (drng_health_fail == exp_fail)
         else begin
            mismatch_count++;
            $display("MISMATCH at %0t: health_fail %b expected %b", $time,
                     drng_health_fail, exp_fail);
         end
         if (!mdl_loaded && (mdl_slot ? seed1_valid : seed0_valid)) begin
            s             = mdl_slot ? seed1 : seed0;
            mdl_key       = s.key;
            mdl_value     = s.value;
            mdl_life      = s.life;
            mdl_seed_life = s.life;
            mdl_loaded    = 1'b1;
            mdl_age       = 0;
         end
         else if (mdl_loaded && mdl_age < 2) begin
            mdl_age++;
         end
         // first word two cycles after the seed is taken.
         exp_valid = mdl_loaded && (mdl_age == 2);
         last      = (mdl_life <= 1);  // zero life ends on the first ack too.
         exp_inv   = drng_ack && mdl_loaded && last;
         assert (seed0_invalidate == (exp_inv && !mdl_slot) &&
                 seed1_invalidate == (exp_inv && mdl_slot) && stat_drbg_reseed == exp_inv)
         else begin
            mismatch_count++;
            $display("MISMATCH at %0t: invalidate %b%b reseed %b, expected slot %0d strobe %b",
                     $time, seed1_invalidate, seed0_invalidate, stat_drbg_reseed,
                     mdl_slot, exp_inv);
         end
         assert (drng_valid == exp_valid)
         else begin
            mismatch_count++;
            $display("MISMATCH at %0t: drng_valid %b expected %b", $time, drng_valid,
                     exp_valid);
         end
         if (drng_valid) begin
            exp_word = ref_word(mdl_key, mdl_value, mdl_seed_life);
            assert (drng_out == exp_word)
            else begin
               mismatch_count++;
               $display("MISMATCH at %0t: drng_out %h expected %h", $time, drng_out, exp_word);
            end
            if (drng_ack) begin
               word_count++;
               exp_fail  = have_prev && (exp_word == prev_word);
               prev_word = exp_word;
               have_prev = 1'b1;
               if (last) begin
                  mdl_slot   = ~mdl_slot;  // next words come from the other slot.
                  mdl_loaded = 1'b0;
               end
               else begin
                  mdl_value = mdl_value + 1'b1;
                  mdl_life  = mdl_life - 1'b1;
               end
            end
         end
      end
   end

   task automatic load_slot(input int slot, input logic [drng_life_w-1:0] life);
      drng_seed_t s;
      s = random_seed(life);
      @(posedge clk);
      if (slot == 0) begin
         seed0       <= s;
         seed0_valid <= 1'b1;
      end
      else begin
         seed1       <= s;
         seed1_valid <= 1'b1;
      end
   endtask

   task automatic wait_valid();
      int n;
      n = 0;
      @(negedge clk);
      while (!drng_valid && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (!drng_valid) begin
         other_count++;
         timed_out = 1'b1;
         $display("timeout at %0t: no word offered within %0d cycles", $time, wait_limit);
      end
   endtask

   // one-cycle acks with random gaps, so words also sit under back-pressure.
   task automatic ack_words(input int count);
      int gap;
      for (int k = 0; k < count && !timed_out; k++) begin
         gap = $urandom % 4;
         repeat (gap) @(posedge clk);
         wait_valid();
         if (!timed_out) begin
            @(posedge clk);
            drng_ack <= 1'b1;
            @(posedge clk);
            drng_ack <= 1'b0;
         end
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      @(negedge clk);
      while (!(drng_idle && drng_seed_expired) && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (!(drng_idle && drng_seed_expired)) begin
         other_count++;
         timed_out = 1'b1;
         $display("timeout at %0t: slots not both empty with the core idle", $time);
      end
      assert (!drng_valid)
      else begin
         mismatch_count++;
         $display("MISMATCH at %0t: drng_valid high with both slots empty", $time);
      end
   endtask

   task automatic check_reset_state();
      @(negedge clk);
      assert (!drng_valid && !drng_health_fail && !seed0_invalidate && !seed1_invalidate &&
              !stat_drbg_reseed && drng_idle && drng_seed_expired)
      else begin
         mismatch_count++;
         $display("MISMATCH at %0t: after reset valid %b fail %b inv %b%b reseed %b idle %b",
                  $time, drng_valid, drng_health_fail, seed1_invalidate, seed0_invalidate,
                  stat_drbg_reseed, drng_idle);
      end
   endtask

   task automatic check_word_count(input int expected);
      assert (word_count == expected)
      else begin
         mismatch_count++;
         $display("MISMATCH at %0t: %0d words taken, expected %0d", $time, word_count,
                  expected);
      end
   endtask

   initial begin
      int life_a;
      int life_b;
      void'($urandom(32'hca5952a5));
      clk            = 1'b0;
      rst_n          = 1'b0;
      seed0          = '0;
      seed1          = '0;
      seed0_valid    = 1'b0;
      seed1_valid    = 1'b0;
      drng_ack       = 1'b0;
      drop_pending   = 2'b00;
      mdl_loaded     = 1'b0;
      mdl_slot       = 1'b0;
      mdl_life       = '0;
      mdl_age        = 0;
      have_prev      = 1'b0;
      exp_fail       = 1'b0;
      timed_out      = 1'b0;
      mismatch_count = 0;
      other_count    = 0;
      word_count     = 0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      check_reset_state();
      // slot 0 for six words, then slot 1 for three.
      load_slot(0, 48'd6);
      load_slot(1, 48'd3);
      ack_words(9);
      wait_drained();
      check_word_count(9);
      // random lives, zero allowed.
      life_a = $urandom % 5;
      life_b = $urandom % 5;
      load_slot(0, life_a);
      load_slot(1, life_b);
      ack_words((life_a == 0 ? 1 : life_a) + (life_b == 0 ? 1 : life_b));
      wait_drained();
      check_word_count(9 + (life_a == 0 ? 1 : life_a) + (life_b == 0 ? 1 : life_b));
      // test mode slot, all zero words.
      load_slot(0, {drng_life_w{1'b1}});
      ack_words(5);
      repeat (2) @(negedge clk);
      $display("errors: %0d mismatches, %0d other, %0d assertion, %0d words checked",
               mismatch_count, other_count, dut0.u_checker.fail_count, word_count);
      if (mismatch_count == 0 && other_count == 0 && dut0.u_checker.fail_count == 0) begin
         $display("sim passed");
      end
      else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
design/drng_pkg.sv
design/drng_seed_select.sv
design/drng_core.sv
design/drng_health_monitor.sv
design/kme_drng_top.sv
test/drng_checker.sv
test/drng_tb.sv
